/* source/dispatch_pkg.sv */
package dispatch_pkg;

	localparam int WORD_W = 32;
	localparam int IDX_W = 5;
	localparam int CMD_W = 5;
	localparam int GR_NUM = 32;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [IDX_W-1:0] reg_idx_t;
	typedef logic [CMD_W-1:0] cmd_t;

	// Any code not listed here reads as zero
	localparam reg_idx_t SYSREG_COREIDR = 5'd1;
	localparam reg_idx_t SYSREG_TIDR = 5'd2;
	localparam reg_idx_t SYSREG_SPR = 5'd4;
	localparam reg_idx_t SYSREG_PSR = 5'd5;
	localparam reg_idx_t SYSREG_PPSR = 5'd11;

	// Interrupt-mode bits 6, 5 and 2 drop on interrupt entry
	localparam word_t PSR_IRQ_CLEAR_MASK = 32'hffff_ff9b;

	// Decoded op from the previous stage
	typedef struct packed {
		logic valid;
		reg_idx_t source0;
		logic source0_sysreg;
		word_t source1;
		logic source1_sysreg;
		logic source1_imm;
		reg_idx_t destination;
		logic destination_sysreg;
		logic writeback;
		cmd_t cmd;
		word_t pc;
	} decoded_op_t;

	// Result being written back this cycle
	typedef struct packed {
		logic valid;
		word_t data;
		reg_idx_t destination;
		logic destination_sysreg;
		logic writeback;
		logic spr_writeback;
		word_t spr;
	} wb_t;

	// Op with resolved operands, to the next stage
	typedef struct packed {
		word_t source0;
		word_t source1;
		reg_idx_t source0_pointer;
		reg_idx_t source1_pointer;
		logic source0_sysreg;
		logic source1_sysreg;
		logic source1_imm;
		reg_idx_t destination;
		logic destination_sysreg;
		logic writeback;
		cmd_t cmd;
		word_t pc;
	} dispatch_op_t;

endpackage

/* source/gr_file.sv */
`timescale 1ns/1ps

module gr_file (
	input logic iCLOCK,
	input logic inRESET,
	input dispatch_pkg::wb_t wb,
	input dispatch_pkg::reg_idx_t rd_idx0,
	input dispatch_pkg::reg_idx_t rd_idx1,
	output dispatch_pkg::word_t rd_data0,
	output dispatch_pkg::word_t rd_data1
);
	import dispatch_pkg::*;

	word_t regs [GR_NUM];
	logic wr_en;

	// General write only when the result is not for a system register
	assign wr_en = wb.valid && wb.writeback && !wb.destination_sysreg;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < GR_NUM; i++) begin
				regs[i] <= '0;
			end
		end
		else if (wr_en) begin
			regs[wb.destination] <= wb.data;
		end
	end

	// Reads return the value from before this cycle's write
	assign rd_data0 = regs[rd_idx0];
	assign rd_data1 = regs[rd_idx1];

	a_wr_idx_known: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		wr_en |-> !$isunknown(wb.destination)
	);

endmodule

/* source/sysreg_file.sv */
`timescale 1ns/1ps

module sysreg_file #(
	parameter dispatch_pkg::word_t CORE_ID = 32'h0
) (
	input logic iCLOCK,
	input logic inRESET,
	input dispatch_pkg::wb_t wb,
	input logic irq_set,
	input logic irq_clr,
	input dispatch_pkg::reg_idx_t rd_idx0,
	input dispatch_pkg::reg_idx_t rd_idx1,
	output dispatch_pkg::word_t rd_data0,
	output dispatch_pkg::word_t rd_data1,
	output dispatch_pkg::word_t psr,
	output dispatch_pkg::word_t ppsr,
	output dispatch_pkg::word_t spr,
	output dispatch_pkg::word_t tidr
);
	import dispatch_pkg::*;

	word_t tidr_q;
	word_t psr_q;
	word_t ppsr_q;
	word_t spr_q;
	logic sys_wr;
	logic spr_load;

	assign sys_wr = wb.valid && wb.writeback && wb.destination_sysreg;
	// Stack pointer update from the result side path
	assign spr_load = wb.valid && wb.spr_writeback;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			tidr_q <= '0;
			psr_q <= '0;
			ppsr_q <= '0;
			spr_q <= '0;
		end
		else begin
			if (sys_wr && wb.destination == SYSREG_TIDR) begin
				tidr_q <= wb.data;
			end

			// Interrupt entry and exit override a PSR write
			if (irq_set) begin
				psr_q <= psr_q & PSR_IRQ_CLEAR_MASK;
			end
			else if (irq_clr) begin
				psr_q <= ppsr_q;
			end
			else if (sys_wr && wb.destination == SYSREG_PSR) begin
				psr_q <= wb.data;
			end

			// Saved copy of PSR on entry
			if (irq_set) begin
				ppsr_q <= psr_q;
			end
			else if (sys_wr && wb.destination == SYSREG_PPSR) begin
				ppsr_q <= wb.data;
			end

			if (spr_load) begin
				spr_q <= wb.spr;
			end
			else if (sys_wr && wb.destination == SYSREG_SPR) begin
				spr_q <= wb.data;
			end
		end
	end

	function automatic word_t read_sysreg(input reg_idx_t idx);
		word_t val;
		case (idx)
			SYSREG_COREIDR: val = CORE_ID;
			SYSREG_TIDR: val = tidr_q;
			SYSREG_SPR: val = spr_q;
			SYSREG_PSR: val = psr_q;
			SYSREG_PPSR: val = ppsr_q;
			default: val = '0;
		endcase
		return val;
	endfunction

	assign rd_data0 = read_sysreg(rd_idx0);
	assign rd_data1 = read_sysreg(rd_idx1);

	assign psr = psr_q;
	assign ppsr = ppsr_q;
	assign spr = spr_q;
	assign tidr = tidr_q;

	a_irq_exclusive: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!(irq_set && irq_clr)
	);

endmodule

/* source/operand_select.sv */
`timescale 1ns/1ps

module operand_select (
	input dispatch_pkg::decoded_op_t prev,
	input dispatch_pkg::wb_t wb,
	input dispatch_pkg::word_t gr_data0,
	input dispatch_pkg::word_t gr_data1,
	input dispatch_pkg::word_t sys_data0,
	input dispatch_pkg::word_t sys_data1,
	output dispatch_pkg::word_t source0,
	output dispatch_pkg::word_t source1
);
	import dispatch_pkg::*;

	typedef struct packed {
		logic hit;
		word_t data;
	} fwd_t;

	fwd_t fwd0;
	fwd_t fwd1;
	reg_idx_t src1_idx;

	// Match one source against the result written back this cycle
	function automatic fwd_t forward(input wb_t w, input reg_idx_t idx, input logic sysreg);
		fwd_t f;
		f.hit = 1'b0;
		f.data = w.data;
		if (w.valid) begin
			if (!sysreg) begin
				f.hit = w.writeback && !w.destination_sysreg && (w.destination == idx);
			end
			else if (idx == SYSREG_SPR && w.spr_writeback) begin
				f.hit = 1'b1;
				f.data = w.spr;
			end
			else begin
				f.hit = w.writeback && w.destination_sysreg && (w.destination == idx);
			end
		end
		return f;
	endfunction

	// Register index sits in the low bits of the immediate field
	assign src1_idx = prev.source1[IDX_W-1:0];

	assign fwd0 = forward(wb, prev.source0, prev.source0_sysreg);
	assign fwd1 = forward(wb, src1_idx, prev.source1_sysreg);

	always_comb begin
		if (fwd0.hit) begin
			source0 = fwd0.data;
		end
		else if (prev.source0_sysreg) begin
			source0 = sys_data0;
		end
		else begin
			source0 = gr_data0;
		end
	end

	// Immediate wins over any register value
	always_comb begin
		if (prev.source1_imm) begin
			source1 = prev.source1;
		end
		else if (fwd1.hit) begin
			source1 = fwd1.data;
		end
		else if (prev.source1_sysreg) begin
			source1 = sys_data1;
		end
		else begin
			source1 = gr_data1;
		end
	end

endmodule

/* source/dispatch_latch.sv */
`timescale 1ns/1ps

module dispatch_latch (
	input logic iCLOCK,
	input logic inRESET,
	input dispatch_pkg::decoded_op_t prev,
	input dispatch_pkg::word_t source0,
	input dispatch_pkg::word_t source1,
	input logic next_lock,
	input logic refresh,
	output logic next_valid,
	output dispatch_pkg::dispatch_op_t next_op,
	output logic prev_lock
);
	import dispatch_pkg::*;

	logic valid_q;
	dispatch_op_t op_q;
	dispatch_op_t op_d;

	always_comb begin
		op_d.source0 = source0;
		op_d.source1 = source1;
		op_d.source0_pointer = prev.source0;
		op_d.source1_pointer = prev.source1[IDX_W-1:0];
		op_d.source0_sysreg = prev.source0_sysreg;
		op_d.source1_sysreg = prev.source1_sysreg;
		op_d.source1_imm = prev.source1_imm;
		op_d.destination = prev.destination;
		op_d.destination_sysreg = prev.destination_sysreg;
		op_d.writeback = prev.writeback;
		op_d.cmd = prev.cmd;
		op_d.pc = prev.pc;
	end

	// Refresh flushes the stage even when locked
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= 1'b0;
			op_q <= '0;
		end
		else if (refresh) begin
			valid_q <= 1'b0;
			op_q <= '0;
		end
		else if (!next_lock) begin
			valid_q <= prev.valid;
			op_q <= op_d;
		end
	end

	assign next_valid = valid_q && !next_lock;
	assign next_op = op_q;
	// Hold the previous stage for as long as we are held
	assign prev_lock = next_lock;

	a_hold_while_locked: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		(next_lock && !refresh) |=> $stable(next_op)
	);

endmodule

/* source/dispatch_top.sv */
`timescale 1ns/1ps

module dispatch_top #(
	parameter dispatch_pkg::word_t CORE_ID = 32'h0
) (
	input logic iCLOCK,
	input logic inRESET,
	input dispatch_pkg::decoded_op_t prev,
	input dispatch_pkg::wb_t wb,
	input logic next_lock,
	input logic refresh,
	input logic irq_set,
	input logic irq_clr,
	output logic prev_lock,
	output logic next_valid,
	output dispatch_pkg::dispatch_op_t next_op,
	output dispatch_pkg::word_t sysreg_psr,
	output dispatch_pkg::word_t sysreg_ppsr,
	output dispatch_pkg::word_t sysreg_spr,
	output dispatch_pkg::word_t sysreg_tidr
);
	import dispatch_pkg::*;

	word_t gr_data0;
	word_t gr_data1;
	word_t sys_data0;
	word_t sys_data1;
	word_t source0;
	word_t source1;

	gr_file u_gr_file (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.wb(wb),
		.rd_idx0(prev.source0),
		.rd_idx1(prev.source1[IDX_W-1:0]),
		.rd_data0(gr_data0),
		.rd_data1(gr_data1)
	);

	sysreg_file #(
		.CORE_ID(CORE_ID)
	) u_sysreg_file (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.wb(wb),
		.irq_set(irq_set),
		.irq_clr(irq_clr),
		.rd_idx0(prev.source0),
		.rd_idx1(prev.source1[IDX_W-1:0]),
		.rd_data0(sys_data0),
		.rd_data1(sys_data1),
		.psr(sysreg_psr),
		.ppsr(sysreg_ppsr),
		.spr(sysreg_spr),
		.tidr(sysreg_tidr)
	);

	operand_select u_operand_select (
		.prev(prev),
		.wb(wb),
		.gr_data0(gr_data0),
		.gr_data1(gr_data1),
		.sys_data0(sys_data0),
		.sys_data1(sys_data1),
		.source0(source0),
		.source1(source1)
	);

	dispatch_latch u_dispatch_latch (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.prev(prev),
		.source0(source0),
		.source1(source1),
		.next_lock(next_lock),
		.refresh(refresh),
		.next_valid(next_valid),
		.next_op(next_op),
		.prev_lock(prev_lock)
	);

endmodule

/* dv/dispatch_checks.sv */
`timescale 1ns/1ps

module dispatch_checks (
	input logic iCLOCK,
	input logic inRESET,
	input logic next_lock,
	input logic refresh,
	input logic prev_lock,
	input logic next_valid,
	input dispatch_pkg::dispatch_op_t next_op,
	input dispatch_pkg::word_t sysreg_psr,
	input dispatch_pkg::word_t sysreg_ppsr,
	input dispatch_pkg::word_t sysreg_spr,
	input dispatch_pkg::word_t sysreg_tidr,
	input logic exp_valid,
	input dispatch_pkg::dispatch_op_t exp_op,
	input dispatch_pkg::word_t exp_psr,
	input dispatch_pkg::word_t exp_ppsr,
	input dispatch_pkg::word_t exp_spr,
	input dispatch_pkg::word_t exp_tidr,
	output logic failed
);

	initial begin
		failed = 1'b0;
	end

	task automatic mismatch(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		$display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		failed = 1'b1;
	endtask

	task automatic broken(input string what);
		$display("Error at %0t: %s", $time, what);
		failed = 1'b1;
	endtask

	// Reset values on the falling edge
	a_reset_valid: assert property (@(negedge iCLOCK) !inRESET |-> !next_valid)
		else mismatch("next_valid", 128'(0), 128'($sampled(next_valid)));

	a_reset_sysregs: assert property (@(negedge iCLOCK)
		!inRESET |-> {sysreg_psr, sysreg_ppsr, sysreg_spr, sysreg_tidr} == '0)
		else mismatch("sysreg_psr/ppsr/spr/tidr", 128'(0),
			$sampled({sysreg_psr, sysreg_ppsr, sysreg_spr, sysreg_tidr}));

	a_prev_lock: assert property (@(posedge iCLOCK) prev_lock == next_lock)
		else mismatch("prev_lock", 128'($sampled(next_lock)), 128'($sampled(prev_lock)));

	a_next_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next_valid == (exp_valid && !next_lock))
		else mismatch("next_valid", 128'($sampled(exp_valid && !next_lock)),
			128'($sampled(next_valid)));

	a_next_op: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next_op == exp_op)
		else mismatch("next_op", 128'($sampled(exp_op)), 128'($sampled(next_op)));

	a_op_held: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(next_lock && !refresh) |=> $stable(next_op))
		else broken("next_op changed while next_lock was high");

	a_refresh_flush: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		refresh |=> !next_valid)
		else broken("next_valid was high on the cycle after a refresh");

	// PSR, PPSR, SPR and TIDR in one word
	a_sysregs: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		{sysreg_psr, sysreg_ppsr, sysreg_spr, sysreg_tidr}
			== {exp_psr, exp_ppsr, exp_spr, exp_tidr})
		else mismatch("sysreg_psr/ppsr/spr/tidr",
			$sampled({exp_psr, exp_ppsr, exp_spr, exp_tidr}),
			$sampled({sysreg_psr, sysreg_ppsr, sysreg_spr, sysreg_tidr}));

endmodule

/* dv/dispatch_tb.sv */
`timescale 1ns/1ps

module dispatch_tb;
	import dispatch_pkg::*;

	localparam word_t CORE_ID = 32'h0000_0003;
	// Tests take about 600 cycles
	localparam int MAX_CYCLES = 2000;

	logic iCLOCK;
	logic inRESET;
	decoded_op_t prev;
	wb_t wb;
	logic next_lock;
	logic refresh;
	logic irq_set;
	logic irq_clr;
	logic prev_lock;
	logic next_valid;
	dispatch_op_t next_op;
	word_t sysreg_psr;
	word_t sysreg_ppsr;
	word_t sysreg_spr;
	word_t sysreg_tidr;

	// Reference model of the registers and of the op in flight
	word_t gr_model [32];
	word_t exp_psr;
	word_t exp_ppsr;
	word_t exp_spr;
	word_t exp_tidr;
	logic exp_valid;
	dispatch_op_t exp_op;
	logic sys_wr;
	logic failed;
	logic [31:0] rng;
	int cycles;

	dispatch_top #(.CORE_ID(CORE_ID)) dut (.*);
	dispatch_checks checks (.*);

	always #2 iCLOCK = ~iCLOCK;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// Forwarded writeback first, then the register the source names
	function automatic word_t expected_source(input reg_idx_t idx, input logic sysreg);
		word_t val;
		if (wb.valid && sysreg && idx == SYSREG_SPR && wb.spr_writeback) begin
			val = wb.spr;
		end
		else if (wb.valid && wb.writeback && wb.destination_sysreg == sysreg
				&& wb.destination == idx) begin
			val = wb.data;
		end
		else if (!sysreg) begin
			val = gr_model[idx];
		end
		else begin
			case (idx)
				SYSREG_COREIDR: val = CORE_ID;
				SYSREG_TIDR: val = exp_tidr;
				SYSREG_SPR: val = exp_spr;
				SYSREG_PSR: val = exp_psr;
				SYSREG_PPSR: val = exp_ppsr;
				default: val = '0;
			endcase
		end
		return val;
	endfunction

	assign sys_wr = wb.valid && wb.writeback && wb.destination_sysreg;

	always @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			gr_model <= '{default: '0};
			exp_psr <= '0;
			exp_ppsr <= '0;
			exp_spr <= '0;
			exp_tidr <= '0;
			exp_valid <= 1'b0;
			exp_op <= '0;
		end
		else begin
			if (refresh) begin
				exp_valid <= 1'b0;
				exp_op <= '0;
			end
			else if (!next_lock) begin
				exp_valid <= prev.valid;
				exp_op <= '{
					source0: expected_source(prev.source0, prev.source0_sysreg),
					source1: prev.source1_imm ? prev.source1 :
						expected_source(prev.source1[IDX_W-1:0], prev.source1_sysreg),
					source0_pointer: prev.source0,
					source1_pointer: prev.source1[IDX_W-1:0],
					source0_sysreg: prev.source0_sysreg,
					source1_sysreg: prev.source1_sysreg,
					source1_imm: prev.source1_imm,
					destination: prev.destination,
					destination_sysreg: prev.destination_sysreg,
					writeback: prev.writeback,
					cmd: prev.cmd,
					pc: prev.pc
				};
			end
			if (wb.valid && wb.writeback && !wb.destination_sysreg) begin
				gr_model[wb.destination] <= wb.data;
			end
			if (sys_wr && wb.destination == SYSREG_TIDR) begin
				exp_tidr <= wb.data;
			end
			if (irq_set) begin
				exp_ppsr <= exp_psr;
				exp_psr <= exp_psr & PSR_IRQ_CLEAR_MASK;
			end
			else begin
				if (irq_clr) begin
					exp_psr <= exp_ppsr;
				end
				else if (sys_wr && wb.destination == SYSREG_PSR) begin
					exp_psr <= wb.data;
				end
				// Interrupt exit leaves PPSR to the writeback
				if (sys_wr && wb.destination == SYSREG_PPSR) begin
					exp_ppsr <= wb.data;
				end
			end
			if (wb.valid && wb.spr_writeback) begin
				exp_spr <= wb.spr;
			end
			else if (sys_wr && wb.destination == SYSREG_SPR) begin
				exp_spr <= wb.data;
			end
		end
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "run stopped");
	endtask

	always @(posedge failed) begin
		stop_with_failure("An assertion in dispatch_checks failed");
	end

	always @(posedge iCLOCK) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			stop_with_failure("Timeout: the run went past the cycle limit");
		end
	end

	// One random op and one random writeback per cycle
	task automatic run_cycles(input int n, input logic sys_ok, input logic fwd, input logic ctl);
		logic [31:0] r;
		repeat (n) begin
			@(negedge iCLOCK);
			r = next_rand();
			wb.valid = r[0] | r[1];
			wb.data = next_rand();
			// Low codes hold most system registers
			wb.destination = (sys_ok && r[2]) ? {2'b00, r[5:3]} : r[7:3];
			wb.destination_sysreg = sys_ok && r[8];
			wb.writeback = r[9] | r[10];
			wb.spr_writeback = sys_ok && r[11] && r[12];
			wb.spr = next_rand();
			prev.valid = r[13] | r[14];
			prev.source0 = (sys_ok && r[15]) ? {2'b00, r[18:16]} : r[20:16];
			prev.source0_sysreg = sys_ok && r[21];
			prev.source1 = next_rand();
			prev.source1_sysreg = sys_ok && r[22];
			prev.source1_imm = r[23] && r[24];
			prev.destination = r[29:25];
			prev.destination_sysreg = r[30];
			prev.writeback = r[31];
			prev.cmd = r[4:0];
			prev.pc = next_rand();
			if (fwd) begin
				prev.source0 = wb.destination;
				prev.source0_sysreg = wb.destination_sysreg;
				prev.source1[IDX_W-1:0] = r[5] ? SYSREG_SPR : wb.destination;
				prev.source1_sysreg = r[5] || wb.destination_sysreg;
				prev.source1_imm = 1'b0;
			end
			r = next_rand();
			next_lock = ctl && r[0];
			refresh = ctl && r[4:2] == 3'b000;
		end
	endtask

	// Load PSR with the mode bits set, then enter and leave interrupt mode
	task automatic irq_round();
		@(negedge iCLOCK);
		next_lock = 1'b0;
		refresh = 1'b0;
		prev.valid = 1'b1;
		prev.source0 = SYSREG_PSR;
		prev.source0_sysreg = 1'b1;
		prev.source1 = {27'd0, SYSREG_PPSR};
		prev.source1_sysreg = 1'b1;
		prev.source1_imm = 1'b0;
		wb = '0;
		wb.valid = 1'b1;
		wb.writeback = 1'b1;
		wb.destination_sysreg = 1'b1;
		wb.destination = SYSREG_PSR;
		wb.data = next_rand() | 32'h0000_0064;
		@(negedge iCLOCK);
		wb = '0;
		irq_set = 1'b1;
		@(negedge iCLOCK);
		irq_set = 1'b0;
		@(negedge iCLOCK);
		irq_clr = 1'b1;
		@(negedge iCLOCK);
		irq_clr = 1'b0;
	endtask

	initial begin
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		rng = 32'hade2f9f1;
		prev = '0;
		wb = '0;
		next_lock = 1'b0;
		refresh = 1'b0;
		irq_set = 1'b0;
		irq_clr = 1'b0;
		repeat (10) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;
		// General registers, then same-cycle forwarding
		run_cycles(150, 1'b0, 1'b0, 1'b0);
		run_cycles(60, 1'b1, 1'b1, 1'b0);
		// System registers and immediates, then lock and refresh
		run_cycles(150, 1'b1, 1'b0, 1'b0);
		run_cycles(150, 1'b1, 1'b0, 1'b1);
		repeat (3) begin
			irq_round();
		end
		repeat (4) @(posedge iCLOCK);
		if (failed) begin
			stop_with_failure("A check failed during the run");
		end
		else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

/* filelist.f */
source/dispatch_pkg.sv
source/gr_file.sv
source/sysreg_file.sv
source/operand_select.sv
source/dispatch_latch.sv
source/dispatch_top.sv
dv/dispatch_checks.sv
dv/dispatch_tb.sv
